//--- verilog/cpuPkg.sv
`default_nettype none

package cpuPkg;

  typedef enum logic [3:0] {
    ADD = 4'd0,  SUB = 4'd1,  AND = 4'd2,  NOR = 4'd3,
    SLL = 4'd4,  SRL = 4'd5,  SRA = 4'd6,  LW  = 4'd7,
    SW  = 4'd8,  LLB = 4'd9,  LHB = 4'd10, B   = 4'd11,
    NOP = 4'd12, JAL = 4'd13, JR  = 4'd14, HLT = 4'd15
  } opcodeT;

  // Branch conditions tested against the flag register
  typedef enum logic [2:0] {
    NE = 3'd0, EQ = 3'd1, GT = 3'd2, LT = 3'd3,
    GE = 3'd4, LE = 3'd5, OV = 3'd6, ALWAYS = 3'd7
  } condT;

  typedef struct packed {
    opcodeT     opcode;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] rt;
  } rFmtT;

  typedef struct packed {
    opcodeT     opcode;
    logic [3:0] rd;
    logic [7:0] imm8;
  } iFmtT;

  typedef struct packed {
    condT       cond;
    logic [8:0] imm9;
  } brFieldT;

  // B carries a condition and offset, JAL a wide offset
  typedef union packed {
    brFieldT     br;
    logic [11:0] imm12;
  } jTailT;

  typedef struct packed {
    opcodeT opcode;
    jTailT  tail;
  } jFmtT;

  typedef union packed {
    rFmtT rFmt;
    iFmtT iFmt;
    jFmtT jFmt;
  } instrT;

  localparam logic [15:0] NOP_WORD = 16'hC000;
  localparam logic [15:0] RESET_PC = 16'h0000;

endpackage

`default_nettype wire

//--- verilog/instructionFetch.sv
`default_nettype none

module instructionFetch import cpuPkg::*; #(
  parameter int dataWidth = 16
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 hold,
  input  logic                 redirect,
  input  logic [dataWidth-1:0] redirectAddr,
  output logic [dataWidth-1:0] pc,
  output logic [dataWidth-1:0] pcNext
);

  assign pcNext = pc + 1'b1;

  // Redirect wins over a hold, so a taken branch breaks a halt freeze
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= dataWidth'(RESET_PC);
    end else if (redirect) begin
      pc <= redirectAddr;
    end else if (!hold) begin
      pc <= pcNext;
    end
  end

endmodule

`default_nettype wire

//--- verilog/instructionDecode.sv
`default_nettype none

module instructionDecode import cpuPkg::*; #(
  parameter int dataWidth = 16,
  parameter int regCount = 16
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  instrT                instr,
  input  logic [3:0]           writeAddr,
  input  logic [dataWidth-1:0] writeData,
  input  logic                 writeEnable,
  output logic [dataWidth-1:0] p0, p1,
  output logic [3:0]           p0Addr, p1Addr, regAddr,
  output logic [dataWidth-1:0] imm,
  output opcodeT               aluOp,
  output condT                 cond,
  output logic                 regWe, memRe, memWe, memToReg,
  output logic                 isBranch, isJal, isJr, isHalt,
  output logic [2:0]           flagEn
);

  logic [dataWidth-1:0] regFile [regCount];

  // ****************************************
  // Control decode
  // ****************************************
  assign aluOp = instr.rFmt.opcode;
  assign cond  = instr.jFmt.tail.br.cond;

  // flagEn is {ov, ng, zr}
  always_comb begin
    p0Addr   = instr.rFmt.rs;
    p1Addr   = 4'd0;
    regAddr  = instr.rFmt.rd;
    imm      = '0;
    regWe    = 1'b0;
    memRe    = 1'b0;
    memWe    = 1'b0;
    memToReg = 1'b0;
    isBranch = 1'b0;
    isJal    = 1'b0;
    isJr     = 1'b0;
    isHalt   = 1'b0;
    flagEn   = 3'b000;
    case (aluOp)
      ADD, SUB: begin
        p1Addr = instr.rFmt.rt;
        regWe  = 1'b1;
        flagEn = 3'b111;
      end
      AND, NOR: begin
        p1Addr = instr.rFmt.rt;
        regWe  = 1'b1;
        flagEn = 3'b001;
      end
      SLL, SRL, SRA: begin
        imm    = dataWidth'(instr.rFmt.rt);
        regWe  = 1'b1;
        flagEn = 3'b001;
      end
      LW: begin
        imm      = dataWidth'(instr.rFmt.rt);
        regWe    = 1'b1;
        memRe    = 1'b1;
        memToReg = 1'b1;
      end
      SW: begin
        // Store data comes from rd
        imm    = dataWidth'(instr.rFmt.rt);
        p1Addr = instr.rFmt.rd;
        memWe  = 1'b1;
      end
      LLB, LHB: begin
        // LHB keeps the low byte of rd, so rd is read too
        p0Addr = (aluOp == LHB) ? instr.iFmt.rd : 4'd0;
        imm    = {{(dataWidth-8){instr.iFmt.imm8[7]}}, instr.iFmt.imm8};
        regWe  = 1'b1;
      end
      B: begin
        p0Addr   = 4'd0;
        imm      = {{(dataWidth-9){instr.jFmt.tail.br.imm9[8]}}, instr.jFmt.tail.br.imm9};
        isBranch = 1'b1;
      end
      JAL: begin
        p0Addr  = 4'd0;
        imm     = {{(dataWidth-12){instr.jFmt.tail.imm12[11]}}, instr.jFmt.tail.imm12};
        regAddr = 4'd15;
        regWe   = 1'b1;
        isJal   = 1'b1;
      end
      JR: isJr = 1'b1;
      HLT: begin
        p0Addr = 4'd0;
        isHalt = 1'b1;
      end
      default: p0Addr = 4'd0;
    endcase
  end

  // ****************************************
  // Register file
  // ****************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < regCount; i++) begin
        regFile[i] <= '0;
      end
    end else if (writeEnable && writeAddr != 4'd0) begin
      regFile[writeAddr] <= writeData;
    end
  end

  // Writeback in the same cycle is seen by the read
  function automatic logic [dataWidth-1:0] readPort(input logic [3:0] addr);
    if (addr == 4'd0) begin
      return '0;
    end else if (writeEnable && writeAddr == addr) begin
      return writeData;
    end
    return regFile[addr];
  endfunction

  always_comb begin
    p0 = readPort(p0Addr);
    p1 = readPort(p1Addr);
  end

endmodule

`default_nettype wire

//--- verilog/forwarding.sv
`default_nettype none

module forwarding #(
  parameter int dataWidth = 16
) (
  input  logic [dataWidth-1:0] p0, p1,
  input  logic [3:0]           p0Addr, p1Addr,
  input  logic [3:0]           regAddrMem,
  input  logic                 regWeMem,
  input  logic                 memReMem,
  input  logic [dataWidth-1:0] resultMem,
  input  logic [3:0]           regAddrWb,
  input  logic                 regWeWb,
  input  logic [dataWidth-1:0] writeDataWb,
  output logic [dataWidth-1:0] fwdP0, fwdP1,
  output logic                 loadStall
);

  logic memHit0, memHit1, wbHit0, wbHit1;

  // r0 is never a forwarding source
  assign memHit0 = regWeMem && regAddrMem != 4'd0 && regAddrMem == p0Addr;
  assign memHit1 = regWeMem && regAddrMem != 4'd0 && regAddrMem == p1Addr;
  assign wbHit0  = regWeWb && regAddrWb != 4'd0 && regAddrWb == p0Addr;
  assign wbHit1  = regWeWb && regAddrWb != 4'd0 && regAddrWb == p1Addr;

  // Youngest producer first
  assign fwdP0 = (memHit0 && !memReMem) ? resultMem : (wbHit0 ? writeDataWb : p0);
  assign fwdP1 = (memHit1 && !memReMem) ? resultMem : (wbHit1 ? writeDataWb : p1);

  // Load data only exists after MEM, so wait one cycle and take it from MEM/WB
  assign loadStall = memReMem && (memHit0 || memHit1);

endmodule

`default_nettype wire

//--- verilog/execute.sv
`default_nettype none

module execute import cpuPkg::*; #(
  parameter int dataWidth = 16
) (
  input  logic [dataWidth-1:0] p0, p1,
  input  logic [dataWidth-1:0] imm,
  input  logic [dataWidth-1:0] pcNext,
  input  opcodeT               aluOp,
  output logic [dataWidth-1:0] aluResult,
  output logic [dataWidth-1:0] target,
  output logic                 zr, ng, ov
);

  localparam int msb = dataWidth - 1;

  logic [3:0] shamt;

  assign shamt = imm[3:0];

  always_comb begin
    ov = 1'b0;
    case (aluOp)
      ADD: begin
        aluResult = p0 + p1;
        ov = (p0[msb] == p1[msb]) && (aluResult[msb] != p0[msb]);
      end
      SUB: begin
        aluResult = p0 - p1;
        ov = (p0[msb] != p1[msb]) && (aluResult[msb] != p0[msb]);
      end
      AND: aluResult = p0 & p1;
      NOR: aluResult = ~(p0 | p1);
      SLL: aluResult = p0 << shamt;
      SRL: aluResult = p0 >> shamt;
      SRA: aluResult = $signed(p0) >>> shamt;
      // Effective address is rs plus the unsigned offset
      LW, SW: aluResult = p0 + imm;
      LLB: aluResult = imm;
      LHB: aluResult = {imm[7:0], p0[dataWidth-9:0]};
      default: aluResult = '0;
    endcase
  end

  assign zr = (aluResult == '0);
  assign ng = aluResult[msb];

  // Branch and JAL are PC-relative, JR goes to rs
  assign target = (aluOp == JR) ? p0 : pcNext + imm;

endmodule

`default_nettype wire

//--- verilog/memoryStage.sv
`default_nettype none

module memoryStage import cpuPkg::*; #(
  parameter int dataWidth = 16
) (
  input  logic                 isBranch, isJal, isJr,
  input  logic                 memRe, memWe,
  input  condT                 cond,
  input  logic                 zr, ng, ov,
  input  logic [dataWidth-1:0] target,
  input  logic [dataWidth-1:0] addr,
  input  logic [dataWidth-1:0] storeData,
  output logic                 redirect,
  output logic [dataWidth-1:0] redirectAddr,
  output logic [dataWidth-1:0] dataAddr,
  output logic [dataWidth-1:0] dataWrData,
  output logic                 dataWe, dataRe
);

  logic taken;

  always_comb begin
    case (cond)
      NE:      taken = !zr;
      EQ:      taken = zr;
      GT:      taken = !zr && !ng;
      LT:      taken = ng;
      GE:      taken = zr || !ng;
      LE:      taken = ng || zr;
      OV:      taken = ov;
      default: taken = 1'b1;
    endcase
  end

  // Jumps are unconditional
  assign redirect     = (isBranch && taken) || isJal || isJr;
  assign redirectAddr = target;

  assign dataAddr   = addr;
  assign dataWrData = storeData;
  assign dataWe     = memWe;
  assign dataRe     = memRe;

endmodule

`default_nettype wire

//--- verilog/cpu.sv
`default_nettype none

module cpu import cpuPkg::*; #(
  parameter int dataWidth = 16,
  parameter int regCount = 16
) (
  input  logic                 clk,
  input  logic                 rst_n,
  output logic [dataWidth-1:0] instrAddr,
  input  logic [15:0]          instr,
  output logic [dataWidth-1:0] dataAddr,
  output logic [dataWidth-1:0] dataWrData,
  output logic                 dataWe,
  output logic                 dataRe,
  input  logic [dataWidth-1:0] dataRdData,
  output logic                 hlt
);

  logic flush, loadStall, fetchFrozen, haltFreeze;
  logic [dataWidth-1:0] pcNextIf, redirectAddr;

  instrT instrId;
  logic [dataWidth-1:0] pcNextId;

  logic [dataWidth-1:0] p0Dec, p1Dec, immDec;
  logic [3:0] p0AddrDec, p1AddrDec, regAddrDec;
  opcodeT aluOpDec;
  condT condDec;
  logic regWeDec, memReDec, memWeDec, memToRegDec;
  logic isBranchDec, isJalDec, isJrDec, isHaltDec;
  logic [2:0] flagEnDec;

  logic [dataWidth-1:0] p0Ex, p1Ex, immEx, pcNextEx;
  logic [3:0] p0AddrEx, p1AddrEx, regAddrEx;
  opcodeT aluOpEx;
  condT condEx;
  logic [10:0] ctrlEx;
  logic [2:0] flagEnEx;

  logic [dataWidth-1:0] fwdP0, fwdP1, aluResultEx, targetEx;
  logic zrEx, ngEx, ovEx;
  // {ov, ng, zr}
  logic [2:0] flags;

  logic [dataWidth-1:0] aluResultMem, targetMem, storeDataMem, pcNextMem, resultMem;
  logic [3:0] regAddrMem;
  condT condMem;
  logic [7:0] ctrlMem;
  logic regWeMem, memReMem, memWeMem, memToRegMem;
  logic isBranchMem, isJalMem, isJrMem, isHaltMem;

  logic [dataWidth-1:0] aluResultWb, loadDataWb, pcNextWb, writeDataWb;
  logic [3:0] regAddrWb;
  logic regWeWb, memToRegWb, isJalWb;

  // ****************************************
  // Fetch and IF/ID
  // ****************************************

  // Fetch stops once a live HLT reaches IF/ID, until reset or a redirect
  assign haltFreeze = isHaltDec || fetchFrozen;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetchFrozen <= 1'b0;
    end else if (flush) begin
      fetchFrozen <= 1'b0;
    end else if (isHaltDec) begin
      fetchFrozen <= 1'b1;
    end
  end

  instructionFetch #(.dataWidth(dataWidth)) u_fetch (
    .clk, .rst_n, .hold(loadStall || haltFreeze),
    .redirect(flush), .redirectAddr,
    .pc(instrAddr), .pcNext(pcNextIf));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instrId <= NOP_WORD;
    end else if (flush || (haltFreeze && !loadStall)) begin
      instrId <= NOP_WORD;
    end else if (!loadStall) begin
      instrId <= instr;
    end
  end

  always_ff @(posedge clk) begin
    if (!loadStall) begin
      pcNextId <= pcNextIf;
    end
  end

  // ****************************************
  // Decode and ID/EX
  // ****************************************
  instructionDecode #(.dataWidth(dataWidth), .regCount(regCount)) u_decode (
    .clk, .rst_n, .instr(instrId),
    .writeAddr(regAddrWb), .writeData(writeDataWb), .writeEnable(regWeWb),
    .p0(p0Dec), .p1(p1Dec), .p0Addr(p0AddrDec), .p1Addr(p1AddrDec),
    .regAddr(regAddrDec), .imm(immDec), .aluOp(aluOpDec), .cond(condDec),
    .regWe(regWeDec), .memRe(memReDec), .memWe(memWeDec), .memToReg(memToRegDec),
    .isBranch(isBranchDec), .isJal(isJalDec), .isJr(isJrDec), .isHalt(isHaltDec),
    .flagEn(flagEnDec));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrlEx <= '0;
    end else if (flush) begin
      ctrlEx <= '0;
    end else if (!loadStall) begin
      ctrlEx <= {regWeDec, memReDec, memWeDec, memToRegDec,
                 isBranchDec, isJalDec, isJrDec, isHaltDec, flagEnDec};
    end
  end

  assign flagEnEx = ctrlEx[2:0];

  always_ff @(posedge clk) begin
    if (!loadStall) begin
      p0Ex      <= p0Dec;
      p1Ex      <= p1Dec;
      p0AddrEx  <= p0AddrDec;
      p1AddrEx  <= p1AddrDec;
      regAddrEx <= regAddrDec;
      immEx     <= immDec;
      aluOpEx   <= aluOpDec;
      condEx    <= condDec;
      pcNextEx  <= pcNextId;
    end
  end

  // ****************************************
  // Execute, flags and EX/MEM
  // ****************************************
  forwarding #(.dataWidth(dataWidth)) u_forwarding (
    .p0(p0Ex), .p1(p1Ex), .p0Addr(p0AddrEx), .p1Addr(p1AddrEx),
    .regAddrMem, .regWeMem, .memReMem, .resultMem,
    .regAddrWb, .regWeWb, .writeDataWb,
    .fwdP0, .fwdP1, .loadStall);

  execute #(.dataWidth(dataWidth)) u_execute (
    .p0(fwdP0), .p1(fwdP1), .imm(immEx), .pcNext(pcNextEx), .aluOp(aluOpEx),
    .aluResult(aluResultEx), .target(targetEx), .zr(zrEx), .ng(ngEx), .ov(ovEx));

  // Flushed or stalled instructions leave the flags alone
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (!flush && !loadStall) begin
      flags <= (flagEnEx & {ovEx, ngEx, zrEx}) | (~flagEnEx & flags);
    end
  end

  // Load-use stall inserts a bubble here
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrlMem <= '0;
    end else if (flush || loadStall) begin
      ctrlMem <= '0;
    end else begin
      ctrlMem <= ctrlEx[10:3];
    end
  end

  assign {regWeMem, memReMem, memWeMem, memToRegMem,
          isBranchMem, isJalMem, isJrMem, isHaltMem} = ctrlMem;

  always_ff @(posedge clk) begin
    aluResultMem <= aluResultEx;
    targetMem    <= targetEx;
    storeDataMem <= fwdP1;
    pcNextMem    <= pcNextEx;
    regAddrMem   <= regAddrEx;
    condMem      <= condEx;
  end

  assign resultMem = isJalMem ? pcNextMem : aluResultMem;

  // ****************************************
  // Memory, MEM/WB and writeback
  // ****************************************
  memoryStage #(.dataWidth(dataWidth)) u_memory (
    .isBranch(isBranchMem), .isJal(isJalMem), .isJr(isJrMem),
    .memRe(memReMem), .memWe(memWeMem), .cond(condMem),
    .zr(flags[0]), .ng(flags[1]), .ov(flags[2]),
    .target(targetMem), .addr(aluResultMem), .storeData(storeDataMem),
    .redirect(flush), .redirectAddr, .dataAddr, .dataWrData, .dataWe, .dataRe);

  // Sticky until reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hlt <= 1'b0;
    end else if (isHaltMem) begin
      hlt <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regWeWb    <= 1'b0;
      memToRegWb <= 1'b0;
      isJalWb    <= 1'b0;
    end else begin
      regWeWb    <= regWeMem;
      memToRegWb <= memToRegMem;
      isJalWb    <= isJalMem;
    end
  end

  always_ff @(posedge clk) begin
    aluResultWb <= aluResultMem;
    loadDataWb  <= dataRdData;
    pcNextWb    <= pcNextMem;
    regAddrWb   <= regAddrMem;
  end

  assign writeDataWb = memToRegWb ? loadDataWb : (isJalWb ? pcNextWb : aluResultWb);

endmodule

`default_nettype wire

//--- test/cpu_sva.sv
`default_nettype none

module cpu_sva (
  input logic        clk,
  input logic        rst_n,
  input logic        hlt,
  input logic        dataWe,
  input logic        dataRe,
  input logic [15:0] instrAddr
);

  timeunit 1ns;
  timeprecision 100ps;

  // ****************************************
  // Reset and data strobes
  // ****************************************
  hltLowOutOfReset: assert property (@(posedge clk) $rose(rst_n) |-> !hlt)
    else $error("hlt high on the first edge after reset");

  strobesExclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(dataWe && dataRe))
    else $error("dataWe and dataRe high together");

  // ****************************************
  // Halt behavior
  // ****************************************
  hltSticky: assert property (@(posedge clk) disable iff (!rst_n) hlt |=> hlt)
    else $error("hlt dropped without a reset");

  // Fetch is already frozen when hlt rises
  pcFrozen: assert property (@(posedge clk) disable iff (!rst_n)
    hlt |=> $stable(instrAddr))
    else $error("instrAddr moved while halted");

endmodule

`default_nettype wire

//--- test/cpuTb.sv
`default_nettype none

module cpuTb import cpuPkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int patternDepth = 256;
  // Cycles watched after hlt for late stores or a moving PC
  localparam int settleCycles = 6;

  logic        clk;
  logic        rst_n;
  logic [15:0] instrAddr;
  logic [15:0] instr;
  logic [15:0] dataAddr;
  logic [15:0] dataWrData;
  logic        dataWe;
  logic        dataRe;
  logic [15:0] dataRdData;
  logic        hlt;

  logic [15:0] patterns [patternDepth];
  logic [15:0] dataMem [65536] = '{default: 16'h0000};
  int          progLen = 0;
  int          storeCount = 0;
  int          storeBase = 0;
  int          storesSeen = 0;
  int          cycleCount = 0;
  int          cycleLimit = 0;
  logic        running = 1'b0;
  logic        hltSeen = 1'b0;
  logic [15:0] haltPc = 16'h0000;

  cpu #(.dataWidth(16), .regCount(16)) u_dut (
    .clk, .rst_n, .instrAddr, .instr, .dataAddr, .dataWrData,
    .dataWe, .dataRe, .dataRdData, .hlt);

  bind cpu cpu_sva u_sva (
    .clk, .rst_n, .hlt, .dataWe, .dataRe, .instrAddr);

  // ****************************************
  // Memory models
  // ****************************************

  // Program words follow the length word
  assign instr = (int'(instrAddr) < progLen) ? patterns[int'(instrAddr) + 1] : NOP_WORD;
  // Read data only while the read strobe is high
  assign dataRdData = dataRe ? dataMem[dataAddr] : 16'h0000;

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic checkValue(input logic [15:0] actual, input logic [15:0] expected,
                            input string what);
    if (actual !== expected) begin
      failRun($sformatf("FAILED at %0t: %s is %h, expected %h",
                        $time, what, actual, expected));
    end
  endtask

  // ****************************************
  // Port monitor on every rising edge
  // ****************************************
  always @(posedge clk) begin
    if (running) begin
      cycleCount++;
      if (cycleCount > cycleLimit) begin
        failRun($sformatf("Timeout: hlt never rose within %0d cycles", cycleLimit));
      end
      checkValue({15'd0, dataWe && dataRe}, 16'd0, "read and write strobes together");
      if (hltSeen) begin
        checkValue({15'd0, hlt}, 16'd1, "hlt after it rose");
        checkValue(instrAddr, haltPc, "instrAddr while halted");
      end else if (hlt) begin
        hltSeen = 1'b1;
        haltPc  = instrAddr;
      end
      if (dataWe) begin
        if (storesSeen >= storeCount) begin
          failRun($sformatf("Store to address %h came after all %0d expected stores",
                            dataAddr, storeCount));
        end else begin
          checkValue(dataAddr, patterns[storeBase + 2 * storesSeen], "store address");
          checkValue(dataWrData, patterns[storeBase + 2 * storesSeen + 1], "store data");
          dataMem[dataAddr] <= dataWrData;
          storesSeen++;
        end
      end
    end
  end

  // ****************************************
  // Reset, run until halt, final count
  // ****************************************
  initial begin
    rst_n = 1'b0;
    $readmemh("test/cpuPatterns.hex", patterns);
    progLen    = int'(patterns[0]);
    storeCount = int'(patterns[progLen + 1]);
    storeBase  = progLen + 2;
    cycleLimit = 20 * progLen + 200;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n   = 1'b1;
    running = 1'b1;
    checkValue({15'd0, hlt}, 16'd0, "hlt after reset");
    checkValue({14'd0, dataWe, dataRe}, 16'd0, "data strobes after reset");
    while (!hlt) begin
      @(negedge clk);
    end
    repeat (settleCycles) @(negedge clk);
    if (storesSeen == storeCount) begin
      $display("TB PASSED");
      $finish;
    end else begin
      checkValue(16'(storesSeen), 16'(storeCount), "number of stores before halt");
    end
  end

endmodule

`default_nettype wire

//--- test/cpuPatterns.hex
// Word 0 is the program length N, then N program words, then the store count M,
// then M lines of store address and store data
002F
// 0-6: LLB r1,5 / LLB r2,-3 / ADD r3 / SW r3 / SUB r4 / LHB r4 / SW r4
9105 92FD 0312 8300
1412 A412 8401
// 7-16: NOR, AND, shifts and their stores
3541 2652 8502 8603
4713 6854 5954
8704 8805 8906
// 17-21: load-use into an ADD, then a load straight into a store
7A01 0BA1 8B07
7C31 8C08
// 22-26: SUB sets zero, B EQ taken over a HLT and two stores
1D11 B203
F000 810F 820F
// 27-28: B NE not taken, store follows
B002 8109
// 29-35: r14 = 7FFF, ADD overflows, B OV taken over three stores
9EFF AE7F 0DE1
BC03
8D0F 8D0E 8D0D
// 36-39: B GT not taken, store, B LE taken over one store
B403 8D0A
BA01 8D0F
// 40-43: JAL to 44, return lands on the store, then HLT and a dead store
D003 8F0B F000 810F
// 44-46: store r15 in the callee, JR r15, dead store
8F0C E0F0 820F
// Expected stores
000D
0000 0002
0001 1208
0002 EDF2
0003 EDF0
0004 0028
0005 FEDF
0006 0EDF
0007 120D
0008 EDF0
0009 0005
000A 8004
000C 0029
000B 0029

//--- flist.f
verilog/cpuPkg.sv
verilog/instructionFetch.sv
verilog/instructionDecode.sv
verilog/forwarding.sv
verilog/execute.sv
verilog/memoryStage.sv
verilog/cpu.sv
test/cpu_sva.sv
test/cpuTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# Build the CPU testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f flist.f -o cpuSim

# The simulator exits nonzero on failure, the grep below decides the result
output=$(./obj_dir/cpuSim 2>&1) || true
echo "$output"

if grep -qx "TB PASSED" <<< "$output"; then
  exit 0
fi
exit 1
